//--- tb.f
hw/fetch_pkg.sv
hw/apb_if.sv
hw/line_rd_if.sv
hw/icache_fetch.sv
hw/icache_store.sv
hw/apb_arbiter.sv
hw/fetch_top.sv
verification/fetch_checker.sv
verification/tb_fetch.sv

//--- Bender.yml
package:
  name: icache_fetch_frontend

sources:
  - hw/fetch_pkg.sv
  - hw/apb_if.sv
  - hw/line_rd_if.sv
  - hw/icache_fetch.sv
  - hw/icache_store.sv
  - hw/apb_arbiter.sv
  - hw/fetch_top.sv
  - target: simulation
    files:
      - verification/fetch_checker.sv
      - verification/tb_fetch.sv

//--- verification/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;

   localparam int SEED_INIT = 32'h2f16;
   localparam int MEM_WORDS = 1024;  // 4 KB
   localparam int TIMEOUT   = 300;   // Cycles per wait
   localparam int NUM_ITER  = 300;

   logic        clk;
   logic        rst_n;
   logic        fetch_valid;
   logic [31:0] fetch_addr;
   logic [4:0]  fetch_len;
   logic        fetch_abort;
   logic        fetch_ready;
   logic        beat_valid;
   logic [31:0] beat_data;
   logic [2:0]  beat_count;
   logic        fetch_done;
   logic        dp_psel;
   logic        dp_penable;
   logic        dp_pwrite;
   logic [31:0] dp_paddr;
   logic [31:0] dp_pwdata;
   logic [3:0]  dp_pstrb;
   logic        dp_pready;
   logic [31:0] dp_prdata;
   logic        m_psel;
   logic        m_penable;
   logic        m_pwrite;
   logic [31:0] m_paddr;
   logic [31:0] m_pwdata;
   logic [3:0]  m_pstrb;
   logic        m_pready = 1'b0;
   logic [31:0] m_prdata = '0;
   int          errors;
   int          fetches;
   int          dp_xfers;
   integer      seed;
   integer      wait_seed;        // Memory wait states, own stream
   logic [31:0] mem [MEM_WORDS];
   int          wait_left = 0;
   bit          timed_out = 1'b0;

   fetch_top dut0 (.*);
   fetch_checker chk0 (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // ----------------------------------------------------------------------
   // APB memory, random wait states before each pready
   // ----------------------------------------------------------------------
   initial begin
      for (int w = 0; w < MEM_WORDS; w++)
         mem[w] = (w * 32'h9e37_79b1) ^ 32'h2f16_c35a;  // Word index spread over all bits
   end

   always @(posedge clk) begin
      m_pready <= 1'b0;  // One-cycle pulse
      if (rst_n && m_psel && m_penable && !m_pready) begin
         if (wait_left == 0) begin
            m_pready  <= 1'b1;
            m_prdata  <= mem[m_paddr[11:2]];
            wait_left <= $random(wait_seed) & 3;
            if (m_pwrite)
               for (int b = 0; b < 4; b++)
                  if (m_pstrb[b])
                     mem[m_paddr[11:2]][8*b +: 8] <= m_pwdata[8*b +: 8];
         end else begin
            wait_left <= wait_left - 1;
         end
      end
   end

   task automatic end_run();
      $display("fetches %0d data-port transfers %0d errors %0d", fetches, dp_xfers, errors);
      if (timed_out || errors != 0)
         $display("tests failed");
      else
         $display("all tests passed");
      $finish;
   endtask

   task automatic note_timeout(input string what);
      $display("timeout, %s", what);
      timed_out = 1'b1;
   endtask

   task automatic do_fetch(input logic [31:0] addr, input logic [4:0] len,
                           input bit abort, input int abort_at);
      int n;
      @(posedge clk);
      for (n = 0; !fetch_ready && n < TIMEOUT; n++)
         @(posedge clk);
      if (!fetch_ready) begin
         note_timeout("fetch_ready never returned");
      end else begin
         fetch_valid <= 1'b1;
         fetch_addr  <= addr;
         fetch_len   <= len;
         @(posedge clk);  // Accepted here
         fetch_valid <= 1'b0;
         if (len != 0) begin
            for (n = 0; !fetch_done && n < TIMEOUT; n++) begin
               @(posedge clk);
               fetch_abort <= abort && (n == abort_at);  // Single-cycle flush
            end
            if (!fetch_done)
               note_timeout("fetch_done never arrived");
            fetch_abort <= 1'b0;
         end
      end
   endtask

   task automatic dp_access(input bit write, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] strb);
      int n;
      @(posedge clk);
      dp_psel    <= 1'b1;  // Setup phase
      dp_pwrite  <= write;
      dp_paddr   <= addr;
      dp_pwdata  <= data;
      dp_pstrb   <= strb;
      @(posedge clk);
      dp_penable <= 1'b1;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!dp_pready && n < TIMEOUT);
      if (!dp_pready)
         note_timeout("data-port transfer never completed");
      dp_psel    <= 1'b0;
      dp_penable <= 1'b0;
   endtask

   // ----------------------------------------------------------------------
   // Stimulus
   // ----------------------------------------------------------------------
   initial begin
      logic [31:0] fa;
      logic [31:0] da;
      logic [31:0] dd;
      logic [4:0]  fl;
      logic [3:0]  st;
      logic [1:0]  op;
      bit          ab;
      int          at;
      seed        = SEED_INIT;
      wait_seed   = SEED_INIT;
      rst_n       = 1'b0;
      fetch_valid = 1'b0;
      fetch_addr  = '0;
      fetch_len   = '0;
      fetch_abort = 1'b0;
      dp_psel     = 1'b0;
      dp_penable  = 1'b0;
      dp_pwrite   = 1'b0;
      dp_paddr    = '0;
      dp_pwdata   = '0;
      dp_pstrb    = '0;
      fa          = '0;
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      for (int it = 0; it < NUM_ITER && !timed_out; it++) begin
         if ($random(seed) & 1)
            fa = $random(seed) & 32'h3ff;  // Else the same address again, a likely hit
         fl = ($random(seed) & 32'h1f) % 17;  // Zero now and then
         ab = ($random(seed) & 7) == 0;
         at = $random(seed) & 7;
         op = $random(seed) & 3;  // 0 idle, 1 read, 2 and 3 write
         da = $random(seed) & 32'h3fc;
         if (da[9:4] == fa[9:4])
            da[9] = ~da[9];  // Writes stay off the line in flight
         dd = $random(seed);
         st = $random(seed);
         fork
            do_fetch(fa, fl, ab, at);
            if (op != 0)
               dp_access(op[1], da, dd, st);
         join
      end
      repeat (4) @(posedge clk);
      end_run();
   end

endmodule

//--- verification/fetch_checker.sv
`timescale 1ns/1ps

module fetch_checker (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        fetch_valid,
   input  logic [31:0] fetch_addr,
   input  logic [4:0]  fetch_len,
   input  logic        fetch_abort,
   input  logic        fetch_ready,
   input  logic        beat_valid,
   input  logic [31:0] beat_data,
   input  logic [2:0]  beat_count,
   input  logic        fetch_done,
   input  logic        dp_psel,
   input  logic        dp_penable,
   input  logic        dp_pwrite,
   input  logic        dp_pready,
   input  logic [31:0] dp_paddr,
   input  logic [31:0] dp_pwdata,
   input  logic [31:0] dp_prdata,
   input  logic [3:0]  dp_pstrb,
   input  logic        m_psel,
   input  logic        m_penable,
   input  logic        m_pready,
   output int          errors,
   output int          fetches,
   output int          dp_xfers
);

   logic [7:0]  model [4096];  // Byte image of the 4 KB memory
   logic        busy;          // Accepted, fetch_done not yet seen
   logic        aborted;
   logic [11:0] ptr;           // Next byte owed to the queue
   int          left;
   logic        was_setup;     // Memory port, previous cycle
   logic        was_wait;

   initial begin
      logic [31:0] word;
      for (int w = 0; w < 1024; w++) begin
         word = (w * 32'h9e37_79b1) ^ 32'h2f16_c35a;  // Same image as the memory model
         for (int b = 0; b < 4; b++)
            model[4*w + b] = word[8*b +: 8];
      end
   end

   task automatic report_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
      $display("ERROR %s expected %h actual %h at %0t", name, exp, act, $time);
      errors++;
   endtask

   task automatic report_fault(input string what);
      $display("%s at %0t", what, $time);
      errors++;
   endtask

   // ----------------------------------------------------------------------
   // Sampled on every rising edge, beats before done before accept
   // ----------------------------------------------------------------------
   always @(posedge clk) begin
      logic [31:0] exp_w;
      logic [31:0] act_w;
      int          cnt;
      if (!rst_n) begin
         busy      = 1'b0;
         aborted   = 1'b0;
         was_setup = 1'b0;
         was_wait  = 1'b0;
      end else begin
         // Access phase only after a setup phase or a waited access
         if (m_penable && !(m_psel && (was_setup || was_wait)))
            report_fault("memory port access phase without a setup phase");
         was_setup = m_psel && !m_penable;
         was_wait  = m_penable && !m_pready;

         if (dp_psel && dp_penable && dp_pready) begin
            dp_xfers++;
            for (int b = 0; b < 4; b++)
               exp_w[8*b +: 8] = model[dp_paddr[11:2]*4 + b];
            if (dp_pwrite) begin
               for (int b = 0; b < 4; b++)
                  if (dp_pstrb[b])
                     model[dp_paddr[11:2]*4 + b] = dp_pwdata[8*b +: 8];  // Byte merge
            end else if (dp_prdata !== exp_w) begin
               report_value("dp_prdata", exp_w, dp_prdata);
            end
         end

         if (beat_valid) begin
            if (!busy || aborted || left == 0) begin
               report_fault("beat outside the requested bytes of a live fetch");
            end else begin
               cnt = 4 - ptr[1:0];  // Up to the word end
               if (left < cnt)
                  cnt = left;
               exp_w = '0;
               act_w = '0;
               for (int b = 0; b < cnt; b++) begin
                  exp_w[8*b +: 8] = model[ptr + b];
                  act_w[8*b +: 8] = beat_data[8*b +: 8];
               end
               if (beat_count != cnt)
                  report_value("beat_count", cnt, beat_count);
               if (act_w !== exp_w)
                  report_value("beat_data", exp_w, act_w);
               ptr  = ptr + cnt;
               left = left - cnt;
            end
         end

         if (fetch_done) begin
            if (!busy)
               report_fault("fetch_done without an accepted fetch");
            else if (!aborted && left != 0)
               report_value("bytes owed at fetch_done", 0, left);
            if (!fetch_ready)
               report_fault("fetch_ready low after fetch_done");
            busy = 1'b0;
         end

         if (fetch_abort && busy)
            aborted = 1'b1;  // No beat from the next edge on

         if (fetch_valid && fetch_ready && fetch_len != 0) begin
            busy    = 1'b1;
            aborted = 1'b0;
            fetches++;
            ptr     = fetch_addr[11:0];
            left    = 16 - fetch_addr[3:0];  // Stop at the line end
            if (fetch_len < left)
               left = fetch_len;
         end
      end
   end

endmodule

//--- hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
   input  logic                                    clk,
   input  logic                                    rst_n,
   // Fetch side
   input  logic                                    fetch_valid,
   input  logic [fetch_pkg::ADDR_W-1:0]            fetch_addr,
   input  logic [$clog2(fetch_pkg::LINE_BYTES):0]  fetch_len,
   input  logic                                    fetch_abort,
   output logic                                    fetch_ready,
   output logic                                    beat_valid,
   output logic [31:0]                             beat_data,
   output logic [2:0]                              beat_count,
   output logic                                    fetch_done,
   // Data port, APB slave
   input  logic                                    dp_psel,
   input  logic                                    dp_penable,
   input  logic                                    dp_pwrite,
   input  logic [fetch_pkg::ADDR_W-1:0]            dp_paddr,
   input  logic [31:0]                             dp_pwdata,
   input  logic [3:0]                              dp_pstrb,
   output logic                                    dp_pready,
   output logic [31:0]                             dp_prdata,
   // Memory port, APB master
   output logic                                    m_psel,
   output logic                                    m_penable,
   output logic                                    m_pwrite,
   output logic [fetch_pkg::ADDR_W-1:0]            m_paddr,
   output logic [31:0]                             m_pwdata,
   output logic [3:0]                              m_pstrb,
   input  logic                                    m_pready,
   input  logic [31:0]                             m_prdata
);

   apb_if      cache_bus ();  // Store refill to arbiter
   line_rd_if  rd_bus ();
   snoop_if    snp_bus ();

   icache_fetch fetch0 (
      .clk, .rst_n,
      .fetch_valid, .fetch_addr, .fetch_len, .fetch_abort,
      .fetch_ready, .beat_valid, .beat_data, .beat_count, .fetch_done,
      .rd          (rd_bus.master)
   );

   icache_store store0 (
      .clk, .rst_n,
      .rd          (rd_bus.slave),
      .mem         (cache_bus.master),
      .snp         (snp_bus.receiver)
   );

   apb_arbiter arb0 (
      .clk, .rst_n,
      .dp_psel, .dp_penable, .dp_pwrite, .dp_paddr, .dp_pwdata, .dp_pstrb,
      .dp_pready, .dp_prdata,
      .m_psel, .m_penable, .m_pwrite, .m_paddr, .m_pwdata, .m_pstrb,
      .m_pready, .m_prdata,
      .cache       (cache_bus.slave),
      .snp         (snp_bus.source)
   );

endmodule

//--- hw/apb_arbiter.sv
`timescale 1ns/1ps

module apb_arbiter (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          dp_psel,
   input  logic                          dp_penable,
   input  logic                          dp_pwrite,
   input  logic [fetch_pkg::ADDR_W-1:0]  dp_paddr,
   input  logic [31:0]                   dp_pwdata,
   input  logic [3:0]                    dp_pstrb,
   output logic                          dp_pready,
   output logic [31:0]                   dp_prdata,
   output logic                          m_psel,
   output logic                          m_penable,
   output logic                          m_pwrite,
   output logic [fetch_pkg::ADDR_W-1:0]  m_paddr,
   output logic [31:0]                   m_pwdata,
   output logic [3:0]                    m_pstrb,
   input  logic                          m_pready,
   input  logic [31:0]                   m_prdata,
   apb_if.slave                          cache,
   snoop_if.source                       snp
);

   fetch_pkg::arb_state_e state;
   logic gnt_dp;     // Grant, 1 is the data port
   logic last_dp;    // Served last
   logic sel_pen;
   logic xfer_done;

   assign sel_pen   = gnt_dp ? dp_penable : cache.penable;
   assign xfer_done = (state == fetch_pkg::ARB_ACCESS) && m_pready;

   // Downstream phases come from the FSM, payload from the granted side
   assign m_psel    = (state != fetch_pkg::ARB_IDLE);
   assign m_penable = (state == fetch_pkg::ARB_ACCESS);
   assign m_pwrite  = gnt_dp ? dp_pwrite : cache.pwrite;
   assign m_paddr   = gnt_dp ? dp_paddr  : cache.paddr;
   assign m_pwdata  = gnt_dp ? dp_pwdata : cache.pwdata;
   assign m_pstrb   = gnt_dp ? dp_pstrb  : cache.pstrb;

   assign dp_pready    = xfer_done && gnt_dp;
   assign dp_prdata    = gnt_dp ? m_prdata : '0;
   assign cache.pready = xfer_done && !gnt_dp;
   assign cache.prdata = gnt_dp ? '0 : m_prdata;

   // Snoop on the completing cycle of a data-port write
   assign snp.we   = dp_pready && dp_pwrite;
   assign snp.addr = dp_paddr;
   assign snp.data = dp_pwdata;
   assign snp.be   = dp_pstrb;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= fetch_pkg::ARB_IDLE;
         gnt_dp  <= 1'b0;
         last_dp <= 1'b0;
      end else begin
         case (state)
            fetch_pkg::ARB_IDLE: begin
               if (dp_psel || cache.psel) begin
                  gnt_dp <= dp_psel && (!cache.psel || !last_dp);  // Round robin on a tie
                  state  <= fetch_pkg::ARB_SETUP;
               end
            end
            fetch_pkg::ARB_SETUP: begin
               if (sel_pen)  // Requester in its access phase
                  state <= fetch_pkg::ARB_ACCESS;
            end
            fetch_pkg::ARB_ACCESS: begin
               if (m_pready) begin
                  last_dp <= gnt_dp;
                  state   <= fetch_pkg::ARB_IDLE;
               end
            end
            default: state <= fetch_pkg::ARB_IDLE;
         endcase
      end
   end

endmodule

//--- hw/icache_store.sv
`timescale 1ns/1ps

module icache_store (
   input  logic         clk,
   input  logic         rst_n,
   line_rd_if.slave     rd,
   apb_if.master        mem,
   snoop_if.receiver    snp
);

   logic [31:0] data_arr [fetch_pkg::NUM_LINES][fetch_pkg::LINE_WORDS];
   logic [fetch_pkg::TAG_W-1:0] tag_arr [fetch_pkg::NUM_LINES];
   logic [fetch_pkg::NUM_LINES-1:0] valid_arr;

   fetch_pkg::store_state_e state;
   logic [fetch_pkg::TAG_W+fetch_pkg::IDX_W-1:0] line;  // Tag and index in service
   logic [$clog2(fetch_pkg::LINE_WORDS)-1:0] wcnt;
   logic [fetch_pkg::IDX_W-1:0] idx;
   logic [fetch_pkg::IDX_W-1:0] req_idx;
   logic [fetch_pkg::IDX_W-1:0] snp_idx;
   logic hit;
   logic refill_wr;
   logic snp_hit;

   assign idx     = line[fetch_pkg::IDX_W-1:0];
   assign req_idx = rd.addr[fetch_pkg::IDX_W+3:4];
   assign snp_idx = snp.addr[fetch_pkg::IDX_W+3:4];

   assign hit = valid_arr[req_idx] &&
                (tag_arr[req_idx] == rd.addr[fetch_pkg::ADDR_W-1 -: fetch_pkg::TAG_W]);

   assign refill_wr = (state == fetch_pkg::ST_REFILL) && mem.penable && mem.pready;

   // A write into the line being refilled must land too, memory words
   // not yet read will already carry it
   assign snp_hit = snp.we &&
      ((valid_arr[snp_idx] &&
        tag_arr[snp_idx] == snp.addr[fetch_pkg::ADDR_W-1 -: fetch_pkg::TAG_W]) ||
       (state == fetch_pkg::ST_REFILL && snp.addr[fetch_pkg::ADDR_W-1:4] == line));

   // ----------------------------------------------------------------------
   // Word return and memory bus
   // ----------------------------------------------------------------------
   assign rd.valid = (state == fetch_pkg::ST_STREAM) || refill_wr;
   assign rd.data  = (state == fetch_pkg::ST_STREAM) ? data_arr[idx][wcnt] : mem.prdata;
   assign rd.done  = rd.valid && (wcnt == 2'd3);

   assign mem.paddr  = {line, wcnt, 2'b00};
   assign mem.pwrite = 1'b0;  // Read only
   assign mem.pwdata = '0;
   assign mem.pstrb  = '0;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state       <= fetch_pkg::ST_IDLE;
         wcnt        <= '0;
         valid_arr   <= '0;
         mem.psel    <= 1'b0;
         mem.penable <= 1'b0;
      end else begin
         case (state)
            fetch_pkg::ST_IDLE: begin
               if (rd.req) begin
                  wcnt <= '0;
                  if (hit) begin
                     state <= fetch_pkg::ST_STREAM;
                  end else begin
                     state              <= fetch_pkg::ST_REFILL;
                     valid_arr[req_idx] <= 1'b0;  // Old line gone
                     mem.psel           <= 1'b1;  // Setup of word 0
                  end
               end
            end
            fetch_pkg::ST_STREAM: begin
               wcnt <= wcnt + 2'd1;
               if (wcnt == 2'd3)
                  state <= fetch_pkg::ST_IDLE;
            end
            fetch_pkg::ST_REFILL: begin
               if (!mem.penable) begin
                  mem.penable <= 1'b1;         // Access phase
               end else if (mem.pready) begin
                  mem.penable <= 1'b0;         // Back to setup, psel held
                  wcnt        <= wcnt + 2'd1;
                  if (wcnt == 2'd3) begin
                     mem.psel       <= 1'b0;
                     valid_arr[idx] <= 1'b1;
                     state          <= fetch_pkg::ST_IDLE;
                  end
               end
            end
            default: state <= fetch_pkg::ST_IDLE;
         endcase
      end
   end

   // Arrays
   always_ff @(posedge clk) begin
      if (state == fetch_pkg::ST_IDLE && rd.req) begin
         line <= rd.addr[fetch_pkg::ADDR_W-1:4];
         if (!hit)
            tag_arr[req_idx] <= rd.addr[fetch_pkg::ADDR_W-1 -: fetch_pkg::TAG_W];
      end
      if (refill_wr)
         data_arr[idx][wcnt] <= mem.prdata;
      if (snp_hit) begin
         for (int b = 0; b < 4; b++) begin
            if (snp.be[b])  // Byte merge
               data_arr[snp_idx][snp.addr[3:2]][8*b +: 8] <= snp.data[8*b +: 8];
         end
      end
   end

endmodule

//--- hw/icache_fetch.sv
`timescale 1ns/1ps

module icache_fetch (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  logic                                    fetch_valid,
   input  logic [fetch_pkg::ADDR_W-1:0]            fetch_addr,
   input  logic [$clog2(fetch_pkg::LINE_BYTES):0]  fetch_len,
   input  logic                                    fetch_abort,
   output logic                                    fetch_ready,
   output logic                                    beat_valid,
   output logic [31:0]                             beat_data,
   output logic [2:0]                              beat_count,
   output logic                                    fetch_done,
   line_rd_if.master                               rd
);

   fetch_pkg::fetch_state_e state;
   logic [3:0]  start;    // Byte offset of the request within the line
   logic [4:0]  remain;   // Bytes still owed to the queue
   logic [1:0]  wcnt;     // Word now on rd.data
   logic        drain;    // Aborted, swallow the rest of the line
   logic        accept;
   logic        emit;
   logic [1:0]  off;
   logic [2:0]  left;
   logic [2:0]  cnt;

   assign fetch_ready = (state == fetch_pkg::FETCH_IDLE);
   assign accept      = fetch_ready && fetch_valid && (fetch_len != '0);  // Zero length ignored

   assign rd.req  = accept;
   assign rd.addr = {fetch_addr[fetch_pkg::ADDR_W-1:4], 4'h0};

   // ----------------------------------------------------------------------
   // Beat sizing
   // ----------------------------------------------------------------------
   assign off  = (wcnt == start[3:2]) ? start[1:0] : 2'd0;  // Only the first word is offset
   assign left = 3'd4 - {1'b0, off};
   assign cnt  = ({2'b00, left} < remain) ? left : remain[2:0];  // Min of the two

   // Words before the start word and after the length pass silently
   assign emit = rd.valid && !drain && !fetch_abort &&
                 (wcnt >= start[3:2]) && (remain != '0);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state      <= fetch_pkg::FETCH_IDLE;
         remain     <= '0;
         wcnt       <= '0;
         drain      <= 1'b0;
         beat_valid <= 1'b0;
         fetch_done <= 1'b0;
      end else begin
         beat_valid <= emit;
         fetch_done <= (state == fetch_pkg::FETCH_READ) && rd.done;  // Also after an abort
         if (accept) begin
            state  <= fetch_pkg::FETCH_READ;
            remain <= fetch_len;
            wcnt   <= '0;
            drain  <= fetch_abort;
         end else if (state == fetch_pkg::FETCH_READ) begin
            if (fetch_abort)
               drain <= 1'b1;
            if (rd.valid)
               wcnt <= wcnt + 2'd1;
            if (emit)
               remain <= remain - {2'b00, cnt};
            if (rd.done)
               state <= fetch_pkg::FETCH_IDLE;  // Store has finished the line
         end
      end
   end

   // Payload only, qualified by beat_valid
   always_ff @(posedge clk) begin
      if (accept)
         start <= fetch_addr[3:0];
      if (emit) begin
         beat_data  <= rd.data >> {off, 3'b000};  // First wanted byte to byte 0
         beat_count <= cnt;
      end
   end

endmodule

//--- hw/line_rd_if.sv
`timescale 1ns/1ps

// Line read, fetch controller to store
interface line_rd_if;
   logic                          req;     // One cycle per line
   logic [fetch_pkg::ADDR_W-1:0]  addr;    // Low 4 bits zero
   logic                          valid;
   logic [31:0]                   data;
   logic                          done;    // With the fourth word

   modport master (output req, addr, input valid, data, done);
   modport slave (input req, addr, output valid, data, done);
endinterface

// Completed data-port writes, arbiter to store
interface snoop_if;
   logic                          we;
   logic [fetch_pkg::ADDR_W-1:0]  addr;
   logic [31:0]                   data;
   logic [3:0]                    be;

   modport source (output we, addr, data, be);
   modport receiver (input we, addr, data, be);
endinterface

//--- hw/apb_if.sv
`timescale 1ns/1ps

interface apb_if;
   logic                          psel;
   logic                          penable;
   logic                          pwrite;
   logic [fetch_pkg::ADDR_W-1:0]  paddr;
   logic [31:0]                   pwdata;
   logic [3:0]                    pstrb;
   logic                          pready;   // Completes the access phase
   logic [31:0]                   prdata;

   modport master (
      output psel, penable, pwrite, paddr, pwdata, pstrb,
      input  pready, prdata
   );

   modport slave (
      input  psel, penable, pwrite, paddr, pwdata, pstrb,
      output pready, prdata
   );
endinterface

//--- hw/fetch_pkg.sv
package fetch_pkg;

   // ----------------------------------------------------------------------
   // Cache geometry
   // ----------------------------------------------------------------------
   localparam int ADDR_W     = 32;  // Byte address
   localparam int LINE_BYTES = 16;
   localparam int LINE_WORDS = 4;   // 32-bit words per line
   localparam int NUM_LINES  = 16;  // Direct mapped
   localparam int IDX_W      = 4;   // Address bits 7..4
   localparam int TAG_W      = 24;  // Address bits 31..8

   // ----------------------------------------------------------------------
   // FSM encodings
   // ----------------------------------------------------------------------
   typedef enum logic [0:0] {
      FETCH_IDLE,
      FETCH_READ   // Waiting on line words from the store
   } fetch_state_e;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_STREAM,   // Hit, words come from the array
      ST_REFILL    // Miss, words come over APB
   } store_state_e;

   typedef enum logic [1:0] {
      ARB_IDLE,
      ARB_SETUP,
      ARB_ACCESS
   } arb_state_e;

endpackage
